// ==== hw/adsr_env.sv ====
`timescale 1ns/1ps

module adsr_env #(
    parameter int ENV_ATTACK_STEP = 4
) (
    input  logic                  clk_100,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic                  env_en,
    input  logic                  env_retrig,
    input  audio_fx_pkg::sample_t in_sample,
    input  audio_fx_pkg::gain_t   sustain,
    output audio_fx_pkg::sample_t env_sample,
    output logic                  env_valid
);
    import audio_fx_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ATTACK,
        DECAY,
        SUSTAIN
    } env_state_t;

    env_state_t         state;
    // spare top bit so attack overshoot would show
    logic [8:0]         gain_acc;
    logic [9:0]         attack_sum;
    gain_t              gain;
    logic signed [24:0] scaled;

    assign gain = gain_acc[7:0];
    assign attack_sum = {1'b0, gain_acc} + 10'(ENV_ATTACK_STEP);

    // gain is unsigned, widen with a zero sign bit
    assign scaled = in_sample * $signed({1'b0, gain});

    // ========================================
    // envelope fsm, one step per sample
    // ========================================
    always_ff @(posedge clk_100) begin
        if (rst) begin
            state    <= IDLE;
            gain_acc <= '0;
        end else if (env_retrig) begin
            // restart from silence
            state    <= ATTACK;
            gain_acc <= '0;
        end else if (in_valid) begin
            case (state)
                ATTACK: begin
                    if (attack_sum >= 10'(GAIN_MAX)) begin
                        gain_acc <= 9'(GAIN_MAX);
                        state    <= DECAY;
                    end else begin
                        gain_acc <= attack_sum[8:0];
                    end
                end
                DECAY: begin
                    if (gain > sustain) begin
                        gain_acc <= gain_acc - 9'd1;
                        if (gain - 8'd1 == sustain) begin
                            state <= SUSTAIN;
                        end
                    end else begin
                        // sustain at or above current gain
                        state <= SUSTAIN;
                    end
                end
                // hold
                SUSTAIN: gain_acc <= gain_acc;
                default: gain_acc <= '0;
            endcase
        end
    end

    // ========================================
    // scaler, uses gain from before the step
    // ========================================
    always_ff @(posedge clk_100) begin
        if (rst) begin
            env_valid <= 1'b0;
        end else begin
            env_valid <= in_valid;
        end
    end

    always_ff @(posedge clk_100) begin
        if (in_valid) begin
            if (env_en) begin
                // >>> 8
                env_sample <= scaled[23:8];
            end else begin
                env_sample <= in_sample;
            end
        end
    end

    gain_saturates: assert property (@(posedge clk_100) disable iff (rst)
        gain_acc <= 9'(GAIN_MAX));

endmodule

// ==== hw/audio_fx_pkg.sv ====
package audio_fx_pkg;

    // ========================================
    // sample stream types
    // ========================================

    // mono or per-channel pcm sample
    typedef logic signed [15:0] sample_t;

    // envelope gain, 255 is close to unity
    typedef logic [7:0] gain_t;

    // pan position, 0 hard left
    typedef logic [7:0] pan_t;

    // echo attenuation as a right shift count
    typedef logic [3:0] shift_t;

    // saturation limits
    localparam sample_t SAMPLE_MAX = 16'sh7fff;
    localparam sample_t SAMPLE_MIN = -16'sh8000;

    // top of the envelope
    localparam gain_t GAIN_MAX = 8'd255;

endpackage

// ==== hw/echo_line.sv ====
`timescale 1ns/1ps

module echo_line #(
    parameter int DELAY_DEPTH = 256
) (
    input  logic                           clk_100,
    input  logic                           rst,
    input  logic                           env_valid,
    input  audio_fx_pkg::sample_t          env_sample,
    input  logic [$clog2(DELAY_DEPTH)-1:0] delay,
    input  audio_fx_pkg::shift_t           atten_shift,
    output audio_fx_pkg::sample_t          echo_sample,
    output logic                           echo_valid
);
    import audio_fx_pkg::*;

    localparam int DW = $clog2(DELAY_DEPTH);

    // ring buffer
    sample_t mem [DELAY_DEPTH];

    logic [DW-1:0] wr_ptr;
    logic [DW-1:0] rd_addr;
    // samples seen since reset, stops at depth
    logic [DW:0]   fill_cnt;
    logic          echo_hit;

    // stage 1 regs
    sample_t cur_q;
    sample_t tap_q;
    logic    tap_en_q;
    logic    valid_q;

    // stage 2 math
    sample_t            tap_scaled;
    logic signed [16:0] sum;

    // entry written delay samples back, wraps
    assign rd_addr = wr_ptr - delay;

    // no tap until that entry exists
    assign echo_hit = (delay != '0) && (fill_cnt >= {1'b0, delay});

    // ========================================
    // stage 1 memory write and tap read
    // ========================================
    always_ff @(posedge clk_100) begin
        if (env_valid) begin
            mem[wr_ptr] <= env_sample;
            tap_q       <= mem[rd_addr];
            cur_q       <= env_sample;
        end
    end

    always_ff @(posedge clk_100) begin
        if (rst) begin
            wr_ptr     <= '0;
            fill_cnt   <= '0;
            tap_en_q   <= 1'b0;
            valid_q    <= 1'b0;
            echo_valid <= 1'b0;
        end else begin
            valid_q    <= env_valid;
            echo_valid <= valid_q;
            if (env_valid) begin
                wr_ptr   <= wr_ptr + 1'b1;
                tap_en_q <= echo_hit;
                if (fill_cnt != (DW+1)'(DELAY_DEPTH)) begin
                    fill_cnt <= fill_cnt + 1'b1;
                end
            end
        end
    end

    // ========================================
    // stage 2 attenuate, add, saturate
    // ========================================
    always_comb begin
        if (tap_en_q) begin
            tap_scaled = tap_q >>> atten_shift;
        end else begin
            tap_scaled = '0;
        end
    end

    // one extra bit catches overflow
    assign sum = {cur_q[15], cur_q} + {tap_scaled[15], tap_scaled};

    always_ff @(posedge clk_100) begin
        if (valid_q) begin
            if (sum[16] != sum[15]) begin
                echo_sample <= sum[16] ? SAMPLE_MIN : SAMPLE_MAX;
            end else begin
                echo_sample <= sum[15:0];
            end
        end
    end

    echo_latency: assert property (@(posedge clk_100) disable iff (rst)
        echo_valid |-> $past(env_valid, 2));

endmodule

// ==== hw/fx_chain_top.sv ====
`timescale 1ns/1ps

module fx_chain_top #(
    parameter int ENV_ATTACK_STEP = 4,
    parameter int DELAY_DEPTH     = 256
) (
    input  logic                   clk_100,
    input  logic                   rst,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  fx_regs_pkg::reg_addr_t wb_adr,
    input  fx_regs_pkg::reg_data_t wb_dat_w,
    input  logic                   in_valid,
    input  audio_fx_pkg::sample_t  in_sample,
    output logic                   wb_ack,
    output fx_regs_pkg::reg_data_t wb_dat_r,
    output logic                   out_valid,
    output audio_fx_pkg::sample_t  out_left,
    output audio_fx_pkg::sample_t  out_right
);
    import audio_fx_pkg::*;

    // settings from the register block
    logic                           env_en;
    logic                           env_retrig;
    gain_t                          sustain;
    logic [$clog2(DELAY_DEPTH)-1:0] delay;
    shift_t                         atten_shift;
    pan_t                           pan;

    // stream between stages
    sample_t env_sample;
    logic    env_valid;
    sample_t echo_sample;
    logic    echo_valid;

    // ========================================
    // control registers
    // ========================================
    fx_ctrl_regs #(.DELAY_DEPTH(DELAY_DEPTH)) regs (
        .clk_100(clk_100), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
        .env_en(env_en), .env_retrig(env_retrig), .sustain(sustain),
        .delay(delay), .atten_shift(atten_shift), .pan(pan)
    );

    // ========================================
    // effects chain, 4 cycles end to end
    // ========================================
    adsr_env #(.ENV_ATTACK_STEP(ENV_ATTACK_STEP)) env (
        .clk_100(clk_100), .rst(rst),
        .in_valid(in_valid), .env_en(env_en), .env_retrig(env_retrig),
        .in_sample(in_sample), .sustain(sustain),
        .env_sample(env_sample), .env_valid(env_valid)
    );

    echo_line #(.DELAY_DEPTH(DELAY_DEPTH)) echo (
        .clk_100(clk_100), .rst(rst),
        .env_valid(env_valid), .env_sample(env_sample),
        .delay(delay), .atten_shift(atten_shift),
        .echo_sample(echo_sample), .echo_valid(echo_valid)
    );

    stereo_pan panner (
        .clk_100(clk_100), .rst(rst),
        .echo_valid(echo_valid), .echo_sample(echo_sample), .pan(pan),
        .out_left(out_left), .out_right(out_right), .out_valid(out_valid)
    );

endmodule

// ==== hw/fx_ctrl_regs.sv ====
`timescale 1ns/1ps

module fx_ctrl_regs #(
    parameter int DELAY_DEPTH = 256
) (
    input  logic                           clk_100,
    input  logic                           rst,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  fx_regs_pkg::reg_addr_t         wb_adr,
    input  fx_regs_pkg::reg_data_t         wb_dat_w,
    output logic                           wb_ack,
    output fx_regs_pkg::reg_data_t         wb_dat_r,
    output logic                           env_en,
    output logic                           env_retrig,
    output audio_fx_pkg::gain_t            sustain,
    output logic [$clog2(DELAY_DEPTH)-1:0] delay,
    output audio_fx_pkg::shift_t           atten_shift,
    output audio_fx_pkg::pan_t             pan
);
    import fx_regs_pkg::*;

    localparam int DW = $clog2(DELAY_DEPTH);

    logic req;
    logic wr_en;
    logic delay_ovf;

    // new request, not the tail of one already acked
    assign req = wb_cyc && wb_stb && !wb_ack;
    assign wr_en = req && wb_we;

    // delay beyond the memory gets clamped
    assign delay_ovf = (wb_dat_w >= reg_data_t'(DELAY_DEPTH));

    // ========================================
    // ack, register writes, retrigger pulse
    // ========================================
    always_ff @(posedge clk_100) begin
        if (rst) begin
            wb_ack      <= 1'b0;
            env_en      <= 1'b0;
            env_retrig  <= 1'b0;
            sustain     <= SUSTAIN_RST;
            delay       <= '0;
            atten_shift <= '0;
            pan         <= PAN_RST;
        end else begin
            wb_ack <= req;
            // one cycle, lines up with the ack
            env_retrig <= wr_en && (wb_adr == ADDR_CTRL) && wb_dat_w[CTRL_RETRIG_BIT];
            if (wr_en) begin
                case (wb_adr)
                    ADDR_CTRL:    env_en <= wb_dat_w[CTRL_EN_BIT];
                    ADDR_SUSTAIN: sustain <= wb_dat_w[7:0];
                    ADDR_DELAY: begin
                        if (delay_ovf) begin
                            delay <= DW'(DELAY_DEPTH - 1);
                        end else begin
                            delay <= wb_dat_w[DW-1:0];
                        end
                    end
                    ADDR_SHIFT:   atten_shift <= wb_dat_w[3:0];
                    ADDR_PAN:     pan <= wb_dat_w[7:0];
                    // unmapped, write dropped
                    default: ;
                endcase
            end
        end
    end

    // readback mux, retrigger bit reads 0
    always_comb begin
        wb_dat_r = '0;
        case (wb_adr)
            ADDR_CTRL:    wb_dat_r[CTRL_EN_BIT] = env_en;
            ADDR_SUSTAIN: wb_dat_r[7:0] = sustain;
            ADDR_DELAY:   wb_dat_r[DW-1:0] = delay;
            ADDR_SHIFT:   wb_dat_r[3:0] = atten_shift;
            ADDR_PAN:     wb_dat_r[7:0] = pan;
            default:      wb_dat_r = '0;
        endcase
    end

    // master keeps the strobe up through the ack cycle
    ack_inside_cycle: assert property (@(posedge clk_100) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb));

endmodule

// ==== hw/fx_regs_pkg.sv ====
package fx_regs_pkg;

    // ========================================
    // register port types
    // ========================================

    // word address on the wishbone port
    typedef logic [2:0] reg_addr_t;

    // register data word
    typedef logic [15:0] reg_data_t;

    // register map
    localparam reg_addr_t ADDR_CTRL    = 3'd0;
    localparam reg_addr_t ADDR_SUSTAIN = 3'd1;
    localparam reg_addr_t ADDR_DELAY   = 3'd2;
    localparam reg_addr_t ADDR_SHIFT   = 3'd3;
    localparam reg_addr_t ADDR_PAN     = 3'd4;

    // ctrl register bits
    localparam int CTRL_EN_BIT     = 0;
    localparam int CTRL_RETRIG_BIT = 1;

    // values after reset, mid-scale
    localparam logic [7:0] SUSTAIN_RST = 8'd128;
    localparam logic [7:0] PAN_RST     = 8'd128;

endpackage

// ==== hw/stereo_pan.sv ====
`timescale 1ns/1ps

module stereo_pan (
    input  logic                  clk_100,
    input  logic                  rst,
    input  logic                  echo_valid,
    input  audio_fx_pkg::sample_t echo_sample,
    input  audio_fx_pkg::pan_t    pan,
    output audio_fx_pkg::sample_t out_left,
    output audio_fx_pkg::sample_t out_right,
    output logic                  out_valid
);
    import audio_fx_pkg::*;

    // weights run 0..256
    logic [8:0] left_weight;
    logic [8:0] right_weight;

    // sample times weight, >>> 8
    function automatic sample_t weigh(sample_t s, logic [8:0] w);
        logic signed [25:0] prod;
        prod = s * $signed({1'b0, w});
        return prod[23:8];
    endfunction

    assign left_weight  = 9'd256 - {1'b0, pan};
    assign right_weight = {1'b0, pan};

    always_ff @(posedge clk_100) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= echo_valid;
        end
    end

    // both channels registered together
    always_ff @(posedge clk_100) begin
        if (echo_valid) begin
            out_left  <= weigh(echo_sample, left_weight);
            out_right <= weigh(echo_sample, right_weight);
        end
    end

endmodule

// ==== verif/fx_chain_tb.sv ====
`timescale 1ns/1ps

module fx_chain_tb;
    import audio_fx_pkg::*;
    import fx_regs_pkg::*;

    // dut defaults
    localparam int ATTACK_STEP = 4;
    localparam int DEPTH       = 256;

    // samples per test
    localparam int PASS_N    = 32;
    localparam int ENV_N     = 120;
    localparam int SUSTAIN_N = 8;
    localparam int ECHO_N    = 48;
    localparam int PAN_N     = 24;
    localparam int RST_N     = 40;
    localparam int REG_OPS   = 40;
    localparam int TOTAL_N   = PASS_N + ENV_N + SUSTAIN_N + ECHO_N + 2 * PAN_N + RST_N;
    // at most 4 cycles per sample or access, plus drains and resets
    localparam int TIMEOUT_CYCLES = TOTAL_N * 4 + REG_OPS * 4 + 1500;

    logic      clk_100;
    logic      rst;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    reg_addr_t wb_adr;
    reg_data_t wb_dat_w;
    logic      wb_ack;
    reg_data_t wb_dat_r;
    logic      in_valid;
    sample_t   in_sample;
    logic      out_valid;
    sample_t   out_left;
    sample_t   out_right;

    // ========================================
    // reference model state
    // ========================================
    typedef enum int {M_IDLE, M_ATTACK, M_DECAY, M_SUSTAIN} env_model_t;

    env_model_t  m_state;
    int          m_gain;
    logic        m_env_en;
    int          m_sustain;
    int          m_delay;
    int          m_shift;
    int          m_pan;
    // envelope outputs since the last reset
    sample_t     hist[$];
    // expected pairs and their arrival cycle
    sample_t     left_q[$];
    sample_t     right_q[$];
    int          due_q[$];
    int          sat_cnt;
    int          cycle_cnt;
    logic [31:0] lfsr;

    fx_chain_top uut (
        .clk_100(clk_100), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .in_valid(in_valid), .in_sample(in_sample),
        .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
        .out_valid(out_valid), .out_left(out_left), .out_right(out_right)
    );

    initial begin
        clk_100 = 1'b0;
        forever #2 clk_100 = ~clk_100;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] lfsr_bits(int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return val;
    endfunction

    // sample times weight, then >>> 8
    function automatic sample_t scale_by(sample_t s, int w);
        int p;
        p = int'(s) * w;
        return sample_t'(p >>> 8);
    endfunction

    function automatic void reset_model();
        m_state   = M_IDLE;
        m_gain    = 0;
        m_env_en  = 1'b0;
        m_sustain = 128;
        m_delay   = 0;
        m_shift   = 0;
        m_pan     = 128;
        hist.delete();
        left_q.delete();
        right_q.delete();
        due_q.delete();
    endfunction

    // one envelope step per accepted sample
    function automatic void step_envelope();
        case (m_state)
            M_ATTACK: begin
                if (m_gain + ATTACK_STEP >= 255) begin
                    m_gain  = 255;
                    m_state = M_DECAY;
                end else begin
                    m_gain = m_gain + ATTACK_STEP;
                end
            end
            M_DECAY: begin
                if (m_gain > m_sustain) begin
                    m_gain = m_gain - 1;
                    if (m_gain == m_sustain) begin
                        m_state = M_SUSTAIN;
                    end
                end else begin
                    m_state = M_SUSTAIN;
                end
            end
            M_SUSTAIN: ;
            default: m_gain = 0;
        endcase
    endfunction

    // full chain for one input sample
    function automatic void predict(sample_t x);
        sample_t env;
        sample_t echo;
        int      tap;
        int      sum;
        int      n;
        env = m_env_en ? scale_by(x, m_gain) : x;
        step_envelope();
        n   = hist.size();
        tap = 0;
        if (m_delay != 0 && n >= m_delay) begin
            tap = int'(hist[n - m_delay]) >>> m_shift;
        end
        hist.push_back(env);
        sum = int'(env) + tap;
        if (sum > 32767) begin
            sat_cnt++;
            echo = 16'sh7fff;
        end else if (sum < -32768) begin
            sat_cnt++;
            echo = -16'sh8000;
        end else begin
            echo = sample_t'(sum);
        end
        left_q.push_back(scale_by(echo, 256 - m_pan));
        right_q.push_back(scale_by(echo, m_pan));
        due_q.push_back(cycle_cnt + 4);
    endfunction

    // ========================================
    // wishbone driver
    // ========================================
    task automatic wb_transfer(input logic we, input reg_addr_t adr,
                               input reg_data_t wdat, output reg_data_t rdat);
        int waited;
        waited = 0;
        @(posedge clk_100);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        @(negedge clk_100);
        while (!wb_ack && waited < 8) begin
            @(negedge clk_100);
            waited++;
        end
        assert (wb_ack && waited == 1)
        else stop_on_error($sformatf("no Wishbone ack one cycle after request to address %0d",
                                     adr));
        rdat = wb_dat_r;
        @(posedge clk_100);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic write_reg(input reg_addr_t adr, input reg_data_t val);
        reg_data_t ignored;
        wb_transfer(1'b1, adr, val, ignored);
        case (adr)
            ADDR_CTRL: begin
                m_env_en = val[0];
                // retrigger restarts from silence
                if (val[1]) begin
                    m_state = M_ATTACK;
                    m_gain  = 0;
                end
            end
            ADDR_SUSTAIN: m_sustain = int'(val[7:0]);
            ADDR_DELAY:   m_delay = (int'(val) >= DEPTH) ? DEPTH - 1 : int'(val);
            ADDR_SHIFT:   m_shift = int'(val[3:0]);
            ADDR_PAN:     m_pan = int'(val[7:0]);
            default: ;
        endcase
    endtask

    task automatic expect_reg(input reg_addr_t adr, input reg_data_t exp);
        reg_data_t got;
        wb_transfer(1'b0, adr, '0, got);
        assert (got == exp)
        else stop_on_error($sformatf("Mismatch at %0t: register %0d read %h, expected %h",
                                     $time, adr, got, exp));
    endtask

    // ========================================
    // sample stream
    // ========================================
    task automatic send_samples(input int n, input logic back_to_back, input logic big);
        sample_t s;
        int      gap;
        for (int i = 0; i < n; i++) begin
            s = sample_t'(lfsr_bits(16));
            // push toward full scale so sums overflow
            if (big && lfsr_bits(1) == 32'd1) begin
                if (s[15]) begin
                    s = sample_t'(-32768 + int'(s[7:0]));
                end else begin
                    s = sample_t'(32767 - int'(s[7:0]));
                end
            end
            gap = back_to_back ? 0 : int'(lfsr_bits(2));
            @(posedge clk_100);
            in_valid  <= 1'b1;
            in_sample <= s;
            predict(s);
            repeat (gap) begin
                @(posedge clk_100);
                in_valid <= 1'b0;
            end
        end
        @(posedge clk_100);
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (due_q.size() != 0) begin
            @(negedge clk_100);
        end
    endtask

    // in-flight samples are dropped with the pipeline
    task automatic apply_reset(input int cycles);
        @(posedge clk_100);
        rst      <= 1'b1;
        in_valid <= 1'b0;
        repeat (cycles - 1) @(posedge clk_100);
        @(negedge clk_100);
        assert (!out_valid)
        else stop_on_error($sformatf("Mismatch at %0t: out_valid high during reset", $time));
        reset_model();
        @(posedge clk_100);
        rst <= 1'b0;
    endtask

    // ========================================
    // output checker and timeout
    // ========================================
    always @(negedge clk_100) begin
        sample_t exp_left;
        sample_t exp_right;
        int      exp_due;
        if (out_valid) begin
            assert (due_q.size() != 0)
            else stop_on_error("output strobe arrived with no sample expected");
            exp_left  = left_q.pop_front();
            exp_right = right_q.pop_front();
            exp_due   = due_q.pop_front();
            assert (cycle_cnt == exp_due)
            else stop_on_error($sformatf("Mismatch at %0t: strobe at cycle %0d, expected %0d",
                                         $time, cycle_cnt, exp_due));
            assert (out_left == exp_left)
            else stop_on_error($sformatf("Mismatch at %0t: left %0d, expected %0d",
                                         $time, out_left, exp_left));
            assert (out_right == exp_right)
            else stop_on_error($sformatf("Mismatch at %0t: right %0d, expected %0d",
                                         $time, out_right, exp_right));
        end
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        lfsr      = 32'hf85c;
        cycle_cnt = 0;
        sat_cnt   = 0;
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        in_valid  = 1'b0;
        in_sample = '0;
        reset_model();
        repeat (16) @(posedge clk_100);
        rst <= 1'b0;

        // register readback, delay clamp, retrigger reads 0
        write_reg(ADDR_CTRL, 16'h0003);
        expect_reg(ADDR_CTRL, 16'h0001);
        write_reg(ADDR_SUSTAIN, 16'h005a);
        expect_reg(ADDR_SUSTAIN, 16'h005a);
        write_reg(ADDR_DELAY, 16'd300);
        expect_reg(ADDR_DELAY, 16'd255);
        write_reg(ADDR_DELAY, 16'd17);
        expect_reg(ADDR_DELAY, 16'd17);
        write_reg(ADDR_SHIFT, 16'd9);
        expect_reg(ADDR_SHIFT, 16'd9);
        write_reg(ADDR_PAN, 16'd77);
        expect_reg(ADDR_PAN, 16'd77);
        write_reg(3'd6, 16'hffff);
        expect_reg(3'd6, 16'h0000);

        // pass-through, half level on both sides
        write_reg(ADDR_CTRL, 16'h0000);
        write_reg(ADDR_DELAY, 16'd0);
        write_reg(ADDR_SHIFT, 16'd0);
        write_reg(ADDR_PAN, 16'd128);
        send_samples(8, 1'b1, 1'b0);
        send_samples(PASS_N - 8, 1'b0, 1'b0);
        wait_drain();

        // attack, decay, sustain
        write_reg(ADDR_SUSTAIN, 16'd200);
        write_reg(ADDR_CTRL, 16'h0003);
        send_samples(ENV_N, 1'b0, 1'b0);
        // gain held at the sustain level
        send_samples(SUSTAIN_N, 1'b0, 1'b0);
        wait_drain();

        // echo from an empty delay line
        apply_reset(4);
        write_reg(ADDR_DELAY, 16'd5);
        write_reg(ADDR_SHIFT, 16'd1);
        sat_cnt = 0;
        send_samples(ECHO_N, 1'b0, 1'b1);
        wait_drain();
        assert (sat_cnt > 0)
        else stop_on_error("echo stream never drove the sum into saturation");

        // hard left, then nearly hard right
        write_reg(ADDR_PAN, 16'd0);
        send_samples(PAN_N, 1'b0, 1'b0);
        wait_drain();
        write_reg(ADDR_PAN, 16'd255);
        send_samples(PAN_N, 1'b0, 1'b0);
        wait_drain();

        // reset with samples still in the pipeline
        write_reg(ADDR_CTRL, 16'h0003);
        send_samples(RST_N / 2 - 4, 1'b0, 1'b0);
        send_samples(4, 1'b1, 1'b0);
        apply_reset(4);
        expect_reg(ADDR_CTRL, 16'h0000);
        expect_reg(ADDR_SUSTAIN, 16'd128);
        expect_reg(ADDR_DELAY, 16'd0);
        expect_reg(ADDR_PAN, 16'd128);
        // fill count restarts
        write_reg(ADDR_DELAY, 16'd3);
        send_samples(RST_N / 4, 1'b0, 1'b0);
        wait_drain();
        // envelope back in idle, gain 0
        write_reg(ADDR_CTRL, 16'h0001);
        send_samples(RST_N / 4, 1'b0, 1'b0);
        wait_drain();

        $display("Test OK");
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/audio_fx_pkg.sv
hw/fx_regs_pkg.sv
hw/fx_ctrl_regs.sv
hw/adsr_env.sv
hw/echo_line.sv
hw/stereo_pan.sv
hw/fx_chain_top.sv
verif/fx_chain_tb.sv
